// File: compile.f
design/lc4_pkg.sv
design/lc4_stage_if.sv
design/lc4_fwd_if.sv
design/lc4_regfile.sv
design/lc4_alu.sv
design/lc4_fetch_decode.sv
design/lc4_execute.sv
design/lc4_mem_writeback.sv
design/lc4_core.sv
dv/lc4_core_asserts.sv
dv/lc4_tb.sv

// File: design/lc4_alu.sv
module lc4_alu (
    input  lc4_pkg::alu_op_e i_op,
    input  lc4_pkg::word_t   i_insn,
    input  lc4_pkg::word_t   i_pc,
    input  lc4_pkg::word_t   i_a,
    input  lc4_pkg::word_t   i_b,
    output lc4_pkg::word_t   o_result,
    output lc4_pkg::word_t   o_target
);
    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm6;
    lc4_pkg::word_t imm9;
    lc4_pkg::word_t opnd_b;

    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    // bit 5 marks the immediate form of ADD and AND
    assign opnd_b = i_insn[5] ? imm5 : i_b;

    // branch target, pc relative
    assign o_target = i_pc + 16'd1 + imm9;

    always_comb begin
        case (i_op)
            lc4_pkg::ALU_ADD:        o_result = i_a + opnd_b;
            lc4_pkg::ALU_MUL:        o_result = i_a * i_b;
            lc4_pkg::ALU_SUB:        o_result = i_a - i_b;
            lc4_pkg::ALU_AND:        o_result = i_a & opnd_b;
            lc4_pkg::ALU_NOT:        o_result = ~i_a;
            lc4_pkg::ALU_OR:         o_result = i_a | i_b;
            lc4_pkg::ALU_XOR:        o_result = i_a ^ i_b;
            lc4_pkg::ALU_PASS_CONST: o_result = imm9;
            // base plus offset for LDR and STR
            lc4_pkg::ALU_ADDR:       o_result = i_a + imm6;
            default:                 o_result = '0;
        endcase
    end

endmodule

// File: design/lc4_core.sv
module lc4_core #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic              gwe,
    input  logic              i_rst_n,
    output lc4_pkg::word_t    o_cur_pc,
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_towrite,
    input  lc4_pkg::word_t    i_dmem_data,
    output lc4_pkg::word_t    o_trace_pc,
    output lc4_pkg::word_t    o_trace_insn,
    output lc4_pkg::stall_e   o_trace_stall,
    output logic              o_trace_rf_we,
    output lc4_pkg::reg_idx_t o_trace_rf_wsel,
    output lc4_pkg::word_t    o_trace_rf_data
);
    logic              redirect;
    lc4_pkg::word_t    target;
    logic              x_is_load;
    lc4_pkg::reg_idx_t x_rd;
    logic              wb_we;
    lc4_pkg::reg_idx_t wb_rd;
    lc4_pkg::word_t    wb_data;

    lc4_stage_if dx ();
    lc4_stage_if xm ();
    lc4_fwd_if   fwd ();

    lc4_fetch_decode #(
        .RESET_PC (RESET_PC)
    ) fetch_decode_i (
        .gwe (gwe), .i_rst_n (i_rst_n), .o_cur_pc (o_cur_pc), .i_insn (i_insn),
        .i_redirect (redirect), .i_target (target),
        .i_x_is_load (x_is_load), .i_x_rd (x_rd),
        .i_wb_we (wb_we), .i_wb_rd (wb_rd), .i_wb_data (wb_data), .dx (dx)
    );

    lc4_execute execute_i (
        .gwe (gwe), .i_rst_n (i_rst_n), .dx (dx), .xm (xm), .fwd (fwd),
        .o_redirect (redirect), .o_target (target),
        .o_x_is_load (x_is_load), .o_x_rd (x_rd)
    );

    lc4_mem_writeback mem_writeback_i (
        .gwe (gwe), .i_rst_n (i_rst_n), .xm (xm), .fwd (fwd),
        .o_dmem_addr (o_dmem_addr), .o_dmem_we (o_dmem_we),
        .o_dmem_towrite (o_dmem_towrite), .i_dmem_data (i_dmem_data),
        .o_wb_we (wb_we), .o_wb_rd (wb_rd), .o_wb_data (wb_data),
        .o_trace_pc (o_trace_pc), .o_trace_insn (o_trace_insn),
        .o_trace_stall (o_trace_stall), .o_trace_rf_we (o_trace_rf_we),
        .o_trace_rf_wsel (o_trace_rf_wsel), .o_trace_rf_data (o_trace_rf_data)
    );

endmodule

// File: design/lc4_execute.sv
module lc4_execute (
    input  logic              gwe,
    input  logic              i_rst_n,
    lc4_stage_if.consumer     dx,
    lc4_stage_if.producer     xm,
    lc4_fwd_if.consumer       fwd,
    output logic              o_redirect,
    output lc4_pkg::word_t    o_target,
    output logic              o_x_is_load,
    output lc4_pkg::reg_idx_t o_x_rd
);
    lc4_pkg::word_t  x_pc;
    lc4_pkg::word_t  x_insn;
    lc4_pkg::dec_t   x_dec;
    lc4_pkg::stall_e x_stall;
    lc4_pkg::word_t  x_a;
    lc4_pkg::word_t  x_b;
    lc4_pkg::word_t  rs_val;
    lc4_pkg::word_t  rt_val;
    lc4_pkg::word_t  alu_result;
    lc4_pkg::nzp_t   nzp_q;
    lc4_pkg::nzp_t   nzp_m;
    lc4_pkg::nzp_t   nzp_cur;

    function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t v);
        if (v == '0) begin
            return lc4_pkg::NZP_ZERO;
        end
        return v[15] ? lc4_pkg::NZP_NEG : lc4_pkg::NZP_POS;
    endfunction

    // MX has priority over WX, the register value comes last
    function automatic lc4_pkg::word_t bypass(input lc4_pkg::reg_idx_t idx,
                                              input lc4_pkg::word_t   reg_val);
        if (fwd.m_we && fwd.m_rd == idx) begin
            return fwd.m_val;
        end
        if (fwd.w_we && fwd.w_rd == idx) begin
            return fwd.w_val;
        end
        return reg_val;
    endfunction

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_insn  <= lc4_pkg::NOP_INSN;
            x_dec   <= '0;
            x_stall <= lc4_pkg::STALL_BRANCH;
        end else begin
            x_insn  <= dx.insn;
            x_dec   <= dx.dec;
            x_stall <= dx.stall;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc <= dx.pc;
        x_a  <= dx.a_val;
        x_b  <= dx.b_val;
    end

    always_comb begin
        rs_val = bypass(x_dec.rs, x_a);
        rt_val = bypass(x_dec.rt, x_b);
    end

    lc4_alu alu_i (
        .i_op     (x_dec.alu_op),
        .i_insn   (x_insn),
        .i_pc     (x_pc),
        .i_a      (rs_val),
        .i_b      (rt_val),
        .o_result (alu_result),
        .o_target (o_target)
    );

    // every register writer in the subset also sets nzp, loads included
    assign nzp_m   = nzp_of(fwd.m_val);
    assign nzp_cur = fwd.m_we ? nzp_m : nzp_q;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            nzp_q <= lc4_pkg::NZP_ZERO;
        end else if (fwd.m_we) begin
            nzp_q <= nzp_m;
        end
    end

    assign o_redirect  = x_dec.is_branch && |(nzp_cur & x_insn[11:9]);
    assign o_x_is_load = x_dec.is_load;
    assign o_x_rd      = x_dec.rd;

    assign xm.pc    = x_pc;
    assign xm.insn  = x_insn;
    assign xm.dec   = x_dec;
    assign xm.stall = x_stall;
    assign xm.a_val = alu_result;
    assign xm.b_val = rt_val;

endmodule

// File: design/lc4_fetch_decode.sv
module lc4_fetch_decode #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic              gwe,
    input  logic              i_rst_n,
    output lc4_pkg::word_t    o_cur_pc,
    input  lc4_pkg::word_t    i_insn,
    input  logic              i_redirect,
    input  lc4_pkg::word_t    i_target,
    input  logic              i_x_is_load,
    input  lc4_pkg::reg_idx_t i_x_rd,
    input  logic              i_wb_we,
    input  lc4_pkg::reg_idx_t i_wb_rd,
    input  lc4_pkg::word_t    i_wb_data,
    lc4_stage_if.producer     dx
);
    lc4_pkg::word_t  pc_q;
    lc4_pkg::word_t  fd_pc;
    lc4_pkg::word_t  fd_insn;
    lc4_pkg::stall_e fd_stall;
    lc4_pkg::dec_t   dec;
    lc4_pkg::word_t  rs_data;
    lc4_pkg::word_t  rt_data;
    logic            load_use;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q     <= RESET_PC;
            fd_insn  <= lc4_pkg::NOP_INSN;
            fd_stall <= lc4_pkg::STALL_BRANCH;
        end else if (i_redirect) begin
            pc_q     <= i_target;
            fd_insn  <= lc4_pkg::NOP_INSN;
            fd_stall <= lc4_pkg::STALL_BRANCH;
        end else if (!load_use) begin
            pc_q     <= pc_q + 16'd1;
            fd_insn  <= i_insn;
            fd_stall <= lc4_pkg::STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!load_use) begin
            fd_pc <= pc_q;
        end
    end

    assign o_cur_pc = pc_q;

    always_comb begin
        dec = '0;
        case (lc4_pkg::opcode_e'(fd_insn[15:12]))
            lc4_pkg::OP_ARITH, lc4_pkg::OP_LOGIC: begin
                dec.rd     = fd_insn[11:9];
                dec.rs     = fd_insn[8:6];
                dec.rt     = fd_insn[2:0];
                dec.rs_re  = 1'b1;
                // NOT and the immediate forms leave rt unread
                dec.rt_re  = !fd_insn[5] && !(fd_insn[15:12] == 4'b0101 && fd_insn[4:3] == 2'b01);
                dec.rf_we  = 1'b1;
                dec.nzp_we = 1'b1;
                if (fd_insn[15:12] == 4'b0001) begin
                    case (fd_insn[5:3])
                        3'b000:  dec.alu_op = lc4_pkg::ALU_ADD;
                        3'b001:  dec.alu_op = lc4_pkg::ALU_MUL;
                        3'b010:  dec.alu_op = lc4_pkg::ALU_SUB;
                        3'b011:  dec = '0;
                        default: dec.alu_op = lc4_pkg::ALU_ADD;
                    endcase
                end else begin
                    case (fd_insn[5:3])
                        3'b001:  dec.alu_op = lc4_pkg::ALU_NOT;
                        3'b010:  dec.alu_op = lc4_pkg::ALU_OR;
                        3'b011:  dec.alu_op = lc4_pkg::ALU_XOR;
                        default: dec.alu_op = lc4_pkg::ALU_AND;
                    endcase
                end
            end
            lc4_pkg::OP_LDR: begin
                dec.rd      = fd_insn[11:9];
                dec.rs      = fd_insn[8:6];
                dec.rs_re   = 1'b1;
                dec.rf_we   = 1'b1;
                dec.nzp_we  = 1'b1;
                dec.is_load = 1'b1;
                dec.alu_op  = lc4_pkg::ALU_ADDR;
            end
            lc4_pkg::OP_STR: begin
                dec.rt       = fd_insn[11:9];
                dec.rs       = fd_insn[8:6];
                dec.rs_re    = 1'b1;
                dec.rt_re    = 1'b1;
                dec.is_store = 1'b1;
                dec.alu_op   = lc4_pkg::ALU_ADDR;
            end
            lc4_pkg::OP_CONST: begin
                dec.rd     = fd_insn[11:9];
                dec.rf_we  = 1'b1;
                dec.nzp_we = 1'b1;
                dec.alu_op = lc4_pkg::ALU_PASS_CONST;
            end
            // an all-zero mask never branches and stays a NOP
            lc4_pkg::OP_BR: dec.is_branch = |fd_insn[11:9];
            default: dec = '0;
        endcase
    end

    // store data is covered by the WM bypass, so its rt does not stall
    assign load_use = i_x_is_load &&
                      ((dec.rs_re && dec.rs == i_x_rd) ||
                       (dec.rt_re && !dec.is_store && dec.rt == i_x_rd));

    lc4_regfile regfile_i (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (dec.rs),
        .i_rt      (dec.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_rd      (i_wb_rd),
        .i_wdata   (i_wb_data),
        .i_we      (i_wb_we)
    );

    always_comb begin
        dx.pc    = fd_pc;
        dx.insn  = fd_insn;
        dx.dec   = dec;
        dx.stall = fd_stall;
        dx.a_val = rs_data;
        dx.b_val = rt_data;
        if (i_redirect || load_use) begin
            dx.insn  = lc4_pkg::NOP_INSN;
            dx.dec   = '0;
            dx.stall = i_redirect ? lc4_pkg::STALL_BRANCH : lc4_pkg::STALL_LOAD;
        end
    end

endmodule

// File: design/lc4_fwd_if.sv
// results of the memory and writeback stages, fed back for bypassing
interface lc4_fwd_if;
    lc4_pkg::reg_idx_t m_rd;
    logic              m_we;
    lc4_pkg::word_t    m_val;
    lc4_pkg::reg_idx_t w_rd;
    logic              w_we;
    lc4_pkg::word_t    w_val;

    modport producer (
        output m_rd, m_we, m_val,
        output w_rd, w_we, w_val
    );

    modport consumer (
        input m_rd, m_we, m_val,
        input w_rd, w_we, w_val
    );

endinterface

// File: design/lc4_mem_writeback.sv
module lc4_mem_writeback (
    input  logic              gwe,
    input  logic              i_rst_n,
    lc4_stage_if.consumer     xm,
    lc4_fwd_if.producer       fwd,
    output lc4_pkg::word_t    o_dmem_addr,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_towrite,
    input  lc4_pkg::word_t    i_dmem_data,
    output logic              o_wb_we,
    output lc4_pkg::reg_idx_t o_wb_rd,
    output lc4_pkg::word_t    o_wb_data,
    output lc4_pkg::word_t    o_trace_pc,
    output lc4_pkg::word_t    o_trace_insn,
    output lc4_pkg::stall_e   o_trace_stall,
    output logic              o_trace_rf_we,
    output lc4_pkg::reg_idx_t o_trace_rf_wsel,
    output lc4_pkg::word_t    o_trace_rf_data
);
    lc4_pkg::word_t  m_pc;
    lc4_pkg::word_t  m_insn;
    lc4_pkg::dec_t   m_dec;
    lc4_pkg::stall_e m_stall;
    lc4_pkg::word_t  m_result;
    lc4_pkg::word_t  m_b;
    lc4_pkg::word_t  w_pc;
    lc4_pkg::word_t  w_insn;
    lc4_pkg::dec_t   w_dec;
    lc4_pkg::stall_e w_stall;
    lc4_pkg::word_t  w_result;
    lc4_pkg::word_t  w_load;
    lc4_pkg::word_t  w_val;
    lc4_pkg::word_t  store_data;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_insn  <= lc4_pkg::NOP_INSN;
            m_dec   <= '0;
            m_stall <= lc4_pkg::STALL_BRANCH;
            w_insn  <= lc4_pkg::NOP_INSN;
            w_dec   <= '0;
            w_stall <= lc4_pkg::STALL_BRANCH;
        end else begin
            m_insn  <= xm.insn;
            m_dec   <= xm.dec;
            m_stall <= xm.stall;
            w_insn  <= m_insn;
            w_dec   <= m_dec;
            w_stall <= m_stall;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc     <= xm.pc;
        m_result <= xm.a_val;
        m_b      <= xm.b_val;
        w_pc     <= m_pc;
        w_result <= m_result;
        w_load   <= i_dmem_data;
    end

    // WM bypass for the store data
    assign store_data = (w_dec.rf_we && w_dec.rd == m_dec.rt) ? w_val : m_b;

    assign o_dmem_we      = m_dec.is_store;
    assign o_dmem_addr    = (m_dec.is_load || m_dec.is_store) ? m_result : '0;
    assign o_dmem_towrite = m_dec.is_store ? store_data : '0;

    assign w_val = w_dec.is_load ? w_load : w_result;

    // load data is already back in this stage
    assign fwd.m_rd  = m_dec.rd;
    assign fwd.m_we  = m_dec.rf_we;
    assign fwd.m_val = m_dec.is_load ? i_dmem_data : m_result;
    assign fwd.w_rd  = w_dec.rd;
    assign fwd.w_we  = w_dec.rf_we;
    assign fwd.w_val = w_val;

    assign o_wb_we   = w_dec.rf_we;
    assign o_wb_rd   = w_dec.rd;
    assign o_wb_data = w_val;

    assign o_trace_pc      = w_pc;
    assign o_trace_insn    = w_insn;
    assign o_trace_stall   = w_stall;
    assign o_trace_rf_we   = w_dec.rf_we;
    assign o_trace_rf_wsel = w_dec.rd;
    assign o_trace_rf_data = w_val;

endmodule

// File: design/lc4_pkg.sv
package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;
    localparam int NZP_W     = 3;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [NZP_W-1:0]     nzp_t;

    // major opcode in insn[15:12], only the supported subset
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_MUL,
        ALU_SUB,
        ALU_AND,
        ALU_NOT,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_CONST,
        ALU_ADDR
    } alu_op_e;

    // code 1 is not used
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_e;

    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rf_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        alu_op_e  alu_op;
    } dec_t;

    localparam word_t NOP_INSN = 16'h0000;

    localparam nzp_t NZP_POS  = 3'b001;
    localparam nzp_t NZP_ZERO = 3'b010;
    localparam nzp_t NZP_NEG  = 3'b100;

endpackage

// File: design/lc4_regfile.sv
module lc4_regfile (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::reg_idx_t i_rs,
    input  lc4_pkg::reg_idx_t i_rt,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data,
    input  lc4_pkg::reg_idx_t i_rd,
    input  lc4_pkg::word_t    i_wdata,
    input  logic              i_we
);
    lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// File: design/lc4_stage_if.sv
// one instruction moving between two pipeline stages
interface lc4_stage_if;
    lc4_pkg::word_t  pc;
    lc4_pkg::word_t  insn;
    lc4_pkg::dec_t   dec;
    lc4_pkg::stall_e stall;
    // operand values, or result and store data past execute
    lc4_pkg::word_t  a_val;
    lc4_pkg::word_t  b_val;

    modport producer (
        output pc, insn, dec, stall,
        output a_val, b_val
    );

    modport consumer (
        input pc, insn, dec, stall,
        input a_val, b_val
    );

endinterface

// File: dv/lc4_core_asserts.sv
module lc4_core_asserts (
    input logic            gwe,
    input logic            i_rst_n,
    input lc4_pkg::word_t  i_cur_pc,
    input logic            i_dmem_we,
    input lc4_pkg::word_t  i_dmem_addr,
    input lc4_pkg::stall_e i_trace_stall,
    input logic            i_trace_rf_we
);
    timeunit 1ns;
    timeprecision 100ps;

    // bubbles never write the register file
    bubble_no_write: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        i_trace_stall != lc4_pkg::STALL_NONE |-> !i_trace_rf_we
    ) else $error("register write on a bubble commit");

    store_addr_known: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        i_dmem_we |-> !$isunknown(i_dmem_addr)
    ) else $error("data memory write with an unknown address");

    pc_known: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        !$isunknown(i_cur_pc)
    ) else $error("fetch pc is unknown");

endmodule

// File: dv/lc4_tb.sv
module lc4_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam lc4_pkg::word_t RESET_PC = 16'h8200;
    localparam int PROG_LEN    = 200;
    localparam int NUM_COMMITS = 180;
    localparam int MAX_CYCLES  = 2000;

    logic              gwe;
    logic              rst_n;
    lc4_pkg::word_t    cur_pc;
    lc4_pkg::word_t    imem_data;
    lc4_pkg::word_t    dmem_addr;
    logic              dmem_we;
    lc4_pkg::word_t    dmem_wdata;
    lc4_pkg::word_t    dmem_rdata;
    lc4_pkg::word_t    trace_pc;
    lc4_pkg::word_t    trace_insn;
    lc4_pkg::stall_e   trace_stall;
    logic              trace_rf_we;
    lc4_pkg::reg_idx_t trace_rf_wsel;
    lc4_pkg::word_t    trace_rf_data;

    lc4_pkg::word_t  prog [PROG_LEN];
    lc4_pkg::word_t  dmem [256];
    // ISA model state
    lc4_pkg::word_t  model_mem [256];
    lc4_pkg::word_t  model_regs [8];
    lc4_pkg::word_t  model_pc;
    lc4_pkg::nzp_t   model_nzp;
    lc4_pkg::word_t  store_addr_q [$];
    lc4_pkg::word_t  store_data_q [$];
    int              bubbles_left;
    lc4_pkg::stall_e bubble_code;
    int              commits;
    int              cycles;
    logic [31:0]     rng;

    lc4_core #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .gwe (gwe), .i_rst_n (rst_n), .o_cur_pc (cur_pc), .i_insn (imem_data),
        .o_dmem_addr (dmem_addr), .o_dmem_we (dmem_we),
        .o_dmem_towrite (dmem_wdata), .i_dmem_data (dmem_rdata),
        .o_trace_pc (trace_pc), .o_trace_insn (trace_insn),
        .o_trace_stall (trace_stall), .o_trace_rf_we (trace_rf_we),
        .o_trace_rf_wsel (trace_rf_wsel), .o_trace_rf_data (trace_rf_data)
    );

    bind lc4_core lc4_core_asserts asserts_i (
        .gwe (gwe), .i_rst_n (i_rst_n), .i_cur_pc (o_cur_pc),
        .i_dmem_we (o_dmem_we), .i_dmem_addr (o_dmem_addr),
        .i_trace_stall (o_trace_stall), .i_trace_rf_we (o_trace_rf_we)
    );

    always #2 gwe = ~gwe;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // registers r0 to r3 only, branches jump 1 to 3 words forward
    function automatic lc4_pkg::word_t gen_insn(input logic [31:0] r);
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [8:0] off;
        rd  = {1'b0, r[1:0]};
        rs  = {1'b0, r[3:2]};
        rt  = {1'b0, r[5:4]};
        off = (r[10:9] == 2'd3) ? 9'd2 : {7'd0, r[10:9]} + 9'd1;
        case (r[31:28])
            4'd0:          return {4'b0001, rd, rs, 3'b000, rt};
            4'd1:          return {4'b0001, rd, rs, 3'b001, rt};
            4'd2:          return {4'b0001, rd, rs, 3'b010, rt};
            4'd3:          return {4'b0001, rd, rs, 1'b1, r[10:6]};
            4'd4, 4'd5:    return {4'b0101, rd, rs, 1'b0, r[7:6], rt};
            4'd6:          return {4'b0101, rd, rs, 1'b1, r[10:6]};
            4'd7, 4'd8:    return {4'b1001, rd, r[14:6]};
            4'd9, 4'd10,
            4'd11:         return {4'b0110, rd, rs, r[11:6]};
            4'd12, 4'd13:  return {4'b0111, rd, rs, r[11:6]};
            default:       return {4'b0000, r[8:6], off};
        endcase
    endfunction

    function automatic lc4_pkg::word_t fetch_insn(input lc4_pkg::word_t pc);
        lc4_pkg::word_t offset;
        offset = pc - RESET_PC;
        if (offset < 16'(PROG_LEN)) begin
            return prog[offset[7:0]];
        end
        return lc4_pkg::NOP_INSN;
    endfunction

    function automatic lc4_pkg::nzp_t sign_flags(input lc4_pkg::word_t v);
        if (v[15]) begin
            return lc4_pkg::NZP_NEG;
        end else if (v == 16'd0) begin
            return lc4_pkg::NZP_ZERO;
        end
        return lc4_pkg::NZP_POS;
    endfunction

    // register reads that a load result cannot reach in time
    function automatic logic reads_reg(input lc4_pkg::word_t insn, input logic [2:0] r);
        logic rs_hit;
        logic rt_hit;
        rs_hit = insn[8:6] == r;
        rt_hit = insn[2:0] == r;
        case (insn[15:12])
            // register forms also read rt
            4'b0001: begin
                case (insn[5:3])
                    3'b000, 3'b001, 3'b010: return rs_hit || rt_hit;
                    3'b011:                 return 1'b0;
                    default:                return rs_hit;
                endcase
            end
            // NOT and the immediate AND read rs only
            4'b0101: begin
                case (insn[5:3])
                    3'b000, 3'b010, 3'b011: return rs_hit || rt_hit;
                    default:                return rs_hit;
                endcase
            end
            4'b0110, 4'b0111: return rs_hit;
            default:          return 1'b0;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic drive_inputs();
        imem_data  = fetch_insn(cur_pc);
        dmem_rdata = dmem[dmem_addr[7:0]];
    endtask

    // the write lands after this cycle's read data was driven
    task automatic capture_store();
        if (dmem_we) begin
            store_addr_q.push_back(dmem_addr);
            store_data_q.push_back(dmem_wdata);
            dmem[dmem_addr[7:0]] = dmem_wdata;
        end
    endtask

    task automatic check_commit();
        lc4_pkg::word_t insn;
        lc4_pkg::word_t a;
        lc4_pkg::word_t b;
        lc4_pkg::word_t res;
        lc4_pkg::word_t addr;
        lc4_pkg::word_t next_pc;
        lc4_pkg::word_t imm5;
        lc4_pkg::word_t imm6;
        lc4_pkg::word_t imm9;
        logic           we;
        if (bubbles_left > 0) begin
            check_value("bubble stall code", 16'(trace_stall), 16'(bubble_code));
            check_value("bubble register write", 16'(trace_rf_we), 16'd0);
            bubbles_left--;
        end else begin
            insn = fetch_insn(model_pc);
            check_value("stall code", 16'(trace_stall), 16'(lc4_pkg::STALL_NONE));
            check_value("trace pc", trace_pc, model_pc);
            check_value("trace insn", trace_insn, insn);
            a       = model_regs[insn[8:6]];
            b       = model_regs[insn[2:0]];
            imm5    = {{11{insn[4]}}, insn[4:0]};
            imm6    = {{10{insn[5]}}, insn[5:0]};
            imm9    = {{7{insn[8]}}, insn[8:0]};
            addr    = a + imm6;
            we      = 1'b0;
            res     = 16'd0;
            next_pc = model_pc + 16'd1;
            case (insn[15:12])
                4'b0001: begin
                    we = 1'b1;
                    if (insn[5]) begin
                        res = a + imm5;
                    end else begin
                        case (insn[4:3])
                            2'b00:   res = a + b;
                            2'b01:   res = a * b;
                            2'b10:   res = a - b;
                            default: we = 1'b0;
                        endcase
                    end
                end
                4'b0101: begin
                    we = 1'b1;
                    if (insn[5]) begin
                        res = a & imm5;
                    end else begin
                        case (insn[4:3])
                            2'b00:   res = a & b;
                            2'b01:   res = ~a;
                            2'b10:   res = a | b;
                            default: res = a ^ b;
                        endcase
                    end
                end
                4'b0110: begin
                    we  = 1'b1;
                    res = model_mem[addr[7:0]];
                end
                4'b0111: begin
                    if (store_addr_q.size() == 0) begin
                        fail_run("a committed STR never wrote the data memory");
                    end else begin
                        check_value("store address", store_addr_q.pop_front(), addr);
                        check_value("store data", store_data_q.pop_front(),
                                    model_regs[insn[11:9]]);
                        model_mem[addr[7:0]] = model_regs[insn[11:9]];
                    end
                end
                4'b1001: begin
                    we  = 1'b1;
                    res = imm9;
                end
                4'b0000: begin
                    if (|(model_nzp & insn[11:9])) begin
                        next_pc      = model_pc + 16'd1 + imm9;
                        bubbles_left = 2;
                        bubble_code  = lc4_pkg::STALL_BRANCH;
                    end
                end
                default: we = 1'b0;
            endcase
            check_value("register write enable", 16'(trace_rf_we), 16'(we));
            if (we) begin
                check_value("register number", 16'(trace_rf_wsel), 16'(insn[11:9]));
                check_value("register data", trace_rf_data, res);
                model_regs[insn[11:9]] = res;
                model_nzp              = sign_flags(res);
            end
            if (insn[15:12] == 4'b0110 && reads_reg(fetch_insn(next_pc), insn[11:9])) begin
                bubbles_left = 1;
                bubble_code  = lc4_pkg::STALL_LOAD;
            end
            model_pc = next_pc;
            commits++;
        end
    endtask

    initial begin
        gwe        = 1'b0;
        rst_n      = 1'b0;
        imem_data  = lc4_pkg::NOP_INSN;
        dmem_rdata = 16'd0;
        rng        = 32'd47;
        for (int i = 0; i < PROG_LEN; i++) begin
            rng     = xorshift(rng);
            prog[i] = gen_insn(rng);
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i]      = {8'(i) ^ 8'h3c, 8'(i)};
            model_mem[i] = {8'(i) ^ 8'h3c, 8'(i)};
        end
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 16'd0;
        end
        model_pc     = RESET_PC;
        model_nzp    = lc4_pkg::NZP_ZERO;
        // four pipeline registers come out of reset as branch bubbles
        bubbles_left = 4;
        bubble_code  = lc4_pkg::STALL_BRANCH;
        commits      = 0;
        cycles       = 0;
        repeat (4) @(posedge gwe);
        #1;
        rst_n = 1'b1;
        drive_inputs();
        #1;
        check_value("pc after reset", cur_pc, RESET_PC);
        check_value("stall after reset", 16'(trace_stall), 16'(lc4_pkg::STALL_BRANCH));
        check_value("register write after reset", 16'(trace_rf_we), 16'd0);
        check_commit();
        capture_store();
        while (commits < NUM_COMMITS && cycles < MAX_CYCLES) begin
            @(posedge gwe);
            #1;
            drive_inputs();
            #1;
            check_commit();
            capture_store();
            cycles++;
        end
        if (commits < NUM_COMMITS) begin
            fail_run("timed out before enough instructions committed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lc4_tb -f compile.f -o lc4_sim
./obj_dir/lc4_sim
